// File: logic/ppu_pkg.sv
// --------------------------------------
// PPU colour path shared definitions
// VGA timing, register map, bus records,
// master colour table and palette defaults
// --------------------------------------
`default_nettype none

package ppu_pkg;

    // --------------------------------------
    // Horizontal timing in pixels
    localparam int H_VISIBLE = 640;
    localparam int H_FRONT   = 16;
    localparam int H_SYNC    = 96;
    localparam int H_BACK    = 48;
    localparam int H_TOTAL   = 800;

    // Vertical timing in lines
    localparam int V_VISIBLE = 480;
    localparam int V_FRONT   = 10;
    localparam int V_SYNC    = 2;
    localparam int V_BACK    = 33;
    localparam int V_TOTAL   = 525;

    // --------------------------------------
    // CPU register indices
    localparam logic [2:0] REG_CTRL   = 3'd0;
    localparam logic [2:0] REG_STATUS = 3'd2;
    localparam logic [2:0] REG_ADDR   = 3'd6;
    localparam logic [2:0] REG_DATA   = 3'd7;

    typedef logic [5:0]  color_idx_t;
    typedef logic [13:0] ppu_addr_t;

    // Palette window start, 32 entries long
    localparam ppu_addr_t PAL_BASE = 14'h3F00;

    // Address steps after a data access
    localparam ppu_addr_t STEP_NARROW = 14'd1;
    localparam ppu_addr_t STEP_WIDE   = 14'd32;

    // Blanking colour
    localparam color_idx_t COLOR_BLACK = 6'h3F;

    // --------------------------------------
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // One CPU register access
    typedef struct packed {
        logic       write;
        logic [2:0] reg_sel;
        logic [7:0] wdata;
    } bus_req_t;

    // One palette access from the register port
    typedef struct packed {
        logic       write;
        logic [4:0] index;
        logic [5:0] wdata;
    } pal_access_t;

    // Beam state per pixel clock
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic active;
        logic vblank_start;
        logic vblank_end;
    } beam_t;

    // Master colour index to 12-bit RGB
    localparam rgb_t MASTER_RGB [64] = '{
        12'h777, 12'h218, 12'h00A, 12'h409, 12'h807, 12'hA01, 12'hA00, 12'h700,
        12'h420, 12'h040, 12'h050, 12'h031, 12'h135, 12'h000, 12'h000, 12'h000,
        12'hBBB, 12'h07E, 12'h23E, 12'h80F, 12'hB0B, 12'hE05, 12'hD20, 12'hC40,
        12'h870, 12'h090, 12'h0A0, 12'h093, 12'h088, 12'h000, 12'h000, 12'h000,
        12'hFFF, 12'h3BF, 12'h59F, 12'hA8F, 12'hF7F, 12'hF7B, 12'hF76, 12'hF93,
        12'hFB3, 12'h8D1, 12'h4D4, 12'h5F9, 12'h0ED, 12'h000, 12'h000, 12'h000,
        12'hFFF, 12'hAEF, 12'hCDF, 12'hDCF, 12'hFCF, 12'hFCD, 12'hFBB, 12'hFDA,
        12'hFEA, 12'hEFA, 12'hAFB, 12'hBFC, 12'h9FF, 12'h000, 12'h000, 12'h000
    };

    // Palette contents after reset
    // Entries 0..15 background, 16..31 sprite
    localparam color_idx_t PAL_RESET [32] = '{
        6'h0F, 6'h16, 6'h30, 6'h38, 6'h00, 6'h16, 6'h26, 6'h07,
        6'h00, 6'h26, 6'h00, 6'h30, 6'h00, 6'h38, 6'h28, 6'h10,
        6'h0F, 6'h16, 6'h27, 6'h12, 6'h0F, 6'h30, 6'h2B, 6'h16,
        6'h0F, 6'h39, 6'h28, 6'h27, 6'h0F, 6'h30, 6'h30, 6'h30
    };

endpackage

`default_nettype wire

// File: logic/video_timing.sv
// --------------------------------------
// VGA beam timing, 800 x 525
// Pixel and line counters with sync,
// active window and frame events
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module video_timing import ppu_pkg::*; (
    input  wire   clock25,
    input  wire   reset_n,
    output beam_t beam_o
);

    logic [9:0] x_q;
    logic [9:0] y_q;
    logic       x_last;
    logic       y_last;

    assign x_last = (x_q == H_TOTAL - 1);
    assign y_last = (y_q == V_TOTAL - 1);

    // Pixel counter wraps into the line counter
    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            x_q <= '0;
            y_q <= '0;
        end else if (x_last) begin
            x_q <= '0;
            y_q <= y_last ? 10'd0 : y_q + 10'd1;
        end else begin
            x_q <= x_q + 10'd1;
        end
    end

    // --------------------------------------
    // Back porch first, then visible, front porch, sync
    always_comb begin
        beam_o.hsync = !(x_q >= H_BACK + H_VISIBLE + H_FRONT &&
                         x_q <  H_BACK + H_VISIBLE + H_FRONT + H_SYNC);
        beam_o.vsync = !(y_q >= V_BACK + V_VISIBLE + V_FRONT &&
                         y_q <  V_BACK + V_VISIBLE + V_FRONT + V_SYNC);
        beam_o.active = (x_q >= H_BACK && x_q < H_BACK + H_VISIBLE) &&
                        (y_q >= V_BACK && y_q < V_BACK + V_VISIBLE);
        // First pixel below the visible area
        beam_o.vblank_start = (x_q == 0) && (y_q == V_BACK + V_VISIBLE);
        beam_o.vblank_end   = (x_q == 0) && (y_q == 0);
    end

    a_beam_in_range: assert property (@(posedge clock25) disable iff (!reset_n)
        x_q < H_TOTAL && y_q < V_TOTAL);

endmodule

`default_nettype wire

// File: logic/palette_ram.sv
// --------------------------------------
// Palette storage
// 32 colour indices, CPU write and read,
// entry 0 drives the backdrop
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module palette_ram import ppu_pkg::*; (
    input  wire         clock25,
    input  wire         reset_n,
    // Access from the register port
    input  wire         pal_en_i,
    input  pal_access_t pal_i,
    output color_idx_t  pal_rdata_o,
    // Universal background colour
    output color_idx_t  backdrop_o
);

    // 0..15 background, 16..31 sprite
    color_idx_t entry_q [32];

    // --------------------------------------
    // Reload defaults on reset, else write on strobe
    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            for (int i = 0; i < 32; i++) begin
                entry_q[i] <= PAL_RESET[i];
            end
        end else if (pal_en_i && pal_i.write) begin
            entry_q[pal_i.index] <= pal_i.wdata;
        end
    end

    // Combinational read of the addressed entry
    assign pal_rdata_o = entry_q[pal_i.index];

    // Backdrop is always entry 0
    assign backdrop_o = entry_q[0];

endmodule

`default_nettype wire

// File: logic/color_out.sv
// --------------------------------------
// RGB output stage
// Backdrop or black through the master
// table, registered together with sync
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module color_out import ppu_pkg::*; (
    input  wire        clock25,
    input  wire        reset_n,
    input  beam_t      beam_i,
    input  color_idx_t backdrop_i,
    output rgb_t       rgb_o,
    output logic       hs_o,
    output logic       vs_o
);

    color_idx_t pick;
    rgb_t       rgb_next;

    // Black outside the visible window
    assign pick     = beam_i.active ? backdrop_i : COLOR_BLACK;
    assign rgb_next = MASTER_RGB[pick];

    // One cycle of latency on colour and sync alike
    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            rgb_o <= '0;
            hs_o  <= 1'b1;
            vs_o  <= 1'b1;
        end else begin
            rgb_o <= rgb_next;
            hs_o  <= beam_i.hsync;
            vs_o  <= beam_i.vsync;
        end
    end

endmodule

`default_nettype wire

// File: logic/ppu_regs.sv
// --------------------------------------
// PPU CPU register port
// Four-phase req/ack slave with control,
// status, address latch and data window
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ppu_regs import ppu_pkg::*; (
    input  wire         clock25,
    input  wire         reset_n,
    // CPU side
    input  wire         req_i,
    input  bus_req_t    bus_i,
    output logic        ack_o,
    output logic [7:0]  rdata_o,
    // Frame events
    input  beam_t       beam_i,
    // Palette side
    input  color_idx_t  pal_rdata_i,
    output pal_access_t pal_o,
    output logic        pal_en_o,
    output logic        nmi_o
);

    logic [7:0] ctrl_q;
    // Set at vblank start, cleared at frame start or status read
    logic       vblank_q;
    // Address write toggle, low means high byte next
    logic       toggle_q;
    ppu_addr_t  addr_q;
    logic       fire;
    logic       in_window;
    ppu_addr_t  step;

    // New request seen while idle
    assign fire = req_i && !ack_o;

    // 3F00..3F1F
    assign in_window = (addr_q[13:5] == PAL_BASE[13:5]);
    assign step      = ctrl_q[2] ? STEP_WIDE : STEP_NARROW;

    // Palette index follows the address register
    assign pal_o.write = bus_i.write;
    assign pal_o.index = addr_q[4:0];
    assign pal_o.wdata = bus_i.wdata[5:0];
    assign pal_en_o    = fire && (bus_i.reg_sel == REG_DATA) && in_window;

    assign nmi_o = vblank_q && ctrl_q[7];

    // --------------------------------------
    // Handshake and register state
    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            ack_o    <= 1'b0;
            ctrl_q   <= 8'h00;
            vblank_q <= 1'b0;
            toggle_q <= 1'b0;
            addr_q   <= '0;
        end else begin
            // Ack up after req, down after req drops
            if (fire)
                ack_o <= 1'b1;
            else if (!req_i)
                ack_o <= 1'b0;

            if (beam_i.vblank_end)
                vblank_q <= 1'b0;

            if (fire) begin
                case (bus_i.reg_sel)
                    REG_CTRL: begin
                        if (bus_i.write)
                            ctrl_q <= bus_i.wdata;
                    end
                    REG_STATUS: begin
                        // Read side effects
                        if (!bus_i.write) begin
                            vblank_q <= 1'b0;
                            toggle_q <= 1'b0;
                        end
                    end
                    REG_ADDR: begin
                        if (bus_i.write) begin
                            // High byte first, 6 bits kept
                            if (!toggle_q)
                                addr_q[13:8] <= bus_i.wdata[5:0];
                            else
                                addr_q[7:0] <= bus_i.wdata;
                            toggle_q <= !toggle_q;
                        end
                    end
                    REG_DATA: begin
                        addr_q <= addr_q + step;
                    end
                    default: begin
                    end
                endcase
            end

            // Set wins over a status read in the same cycle
            if (beam_i.vblank_start)
                vblank_q <= 1'b1;
        end
    end

    // Read data captured with the access
    always_ff @(posedge clock25) begin
        if (fire) begin
            case (bus_i.reg_sel)
                REG_STATUS: rdata_o <= {vblank_q, 7'd0};
                REG_DATA:   rdata_o <= in_window ? {2'b00, pal_rdata_i} : 8'h00;
                default:    rdata_o <= 8'h00;
            endcase
        end
    end

    // --------------------------------------
    // Ack only answers a pending request
    a_ack_after_req: assert property (@(posedge clock25) disable iff (!reset_n)
        $rose(ack_o) |-> $past(req_i));

    // Palette strobe lands on the edge where ack rises
    a_pal_en_with_ack: assert property (@(posedge clock25) disable iff (!reset_n)
        pal_en_o |=> $rose(ack_o));

endmodule

`default_nettype wire

// File: logic/ppu_top.sv
// --------------------------------------
// PPU colour path top level
// Register port, palette, beam timing
// and RGB output
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ppu_top import ppu_pkg::*; (
    input  wire        clock25,
    input  wire        reset_n,
    // CPU register port
    input  wire        req_i,
    input  bus_req_t   bus_i,
    output logic       ack_o,
    output logic [7:0] rdata_o,
    output logic       nmi_o,
    // VGA
    output rgb_t       rgb_o,
    output logic       hs_o,
    output logic       vs_o
);

    pal_access_t pal;
    logic        pal_en;
    color_idx_t  pal_rdata;
    color_idx_t  backdrop;
    beam_t       beam;

    ppu_regs u_regs (
        .clock25     (clock25),
        .reset_n     (reset_n),
        .req_i       (req_i),
        .bus_i       (bus_i),
        .ack_o       (ack_o),
        .rdata_o     (rdata_o),
        .beam_i      (beam),
        .pal_rdata_i (pal_rdata),
        .pal_o       (pal),
        .pal_en_o    (pal_en),
        .nmi_o       (nmi_o)
    );

    palette_ram u_palette (
        .clock25     (clock25),
        .reset_n     (reset_n),
        .pal_en_i    (pal_en),
        .pal_i       (pal),
        .pal_rdata_o (pal_rdata),
        .backdrop_o  (backdrop)
    );

    video_timing u_timing (
        .clock25 (clock25),
        .reset_n (reset_n),
        .beam_o  (beam)
    );

    color_out u_color (
        .clock25    (clock25),
        .reset_n    (reset_n),
        .beam_i     (beam),
        .backdrop_i (backdrop),
        .rgb_o      (rgb_o),
        .hs_o       (hs_o),
        .vs_o       (vs_o)
    );

endmodule

`default_nettype wire

// File: tests/tb_tasks.svh
// --------------------------------------
// PPU testbench helpers
// LFSR stimulus, four-phase bus tasks and
// typed compare tasks
// --------------------------------------
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// --------------------------------------
// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

// One step per bit taken, newest bit at the bottom
task automatic random_bits(input int count, output logic [7:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
        lfsr_q = lfsr_next(lfsr_q);
        value = {value[6:0], lfsr_q[0]};
    end
endtask

// --------------------------------------
// Four-phase access, inputs change on the falling edge
task automatic bus_access(input bus_req_t req, output logic [7:0] data);
    int waited;
    @(negedge clock25);
    bus_i = req;
    req_i = 1'b1;
    waited = 0;
    while (ack_o !== 1'b1) begin
        @(negedge clock25);
        waited++;
    end
    // Slave answers one cycle after req is seen
    if (waited != 1) begin
        $display("%s: ack_o rose %0d cycles after req_i instead of 1",
                 cur_test, waited);
        errors++;
    end
    // rdata_o is valid while ack is high
    data  = rdata_o;
    req_i = 1'b0;
    waited = 0;
    while (ack_o !== 1'b0) begin
        @(negedge clock25);
        waited++;
    end
    if (waited != 1) begin
        $display("%s: ack_o fell %0d cycles after req_i dropped instead of 1",
                 cur_test, waited);
        errors++;
    end
endtask

task automatic bus_write(input logic [2:0] sel, input logic [7:0] wdata);
    bus_req_t   req;
    logic [7:0] ignored;
    req.write   = 1'b1;
    req.reg_sel = sel;
    req.wdata   = wdata;
    bus_access(req, ignored);
endtask

task automatic bus_read(input logic [2:0] sel, output logic [7:0] rdata);
    bus_req_t req;
    req.write   = 1'b0;
    req.reg_sel = sel;
    req.wdata   = 8'h00;
    bus_access(req, rdata);
endtask

// High byte first, upper two bits unused
task automatic set_address(input ppu_addr_t addr);
    bus_write(REG_ADDR, {2'b00, addr[13:8]});
    bus_write(REG_ADDR, addr[7:0]);
endtask

// --------------------------------------
// Compare tasks
task automatic check_byte(input string what, input logic [7:0] expected,
                          input logic [7:0] actual);
    if (actual !== expected) begin
        $display("FAILED %s (%s): expected %02h, actual %02h",
                 cur_test, what, expected, actual);
        errors++;
    end
endtask

task automatic check_rgb(input string what, input rgb_t expected, input rgb_t actual);
    if (actual !== expected) begin
        $display("FAILED %s (%s): expected %03h, actual %03h",
                 cur_test, what, expected, actual);
        errors++;
    end
endtask

`endif

// File: tests/tb_ppu.sv
// --------------------------------------
// PPU colour path testbench
// Directed tests over the register port,
// palette, NMI and VGA output
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_ppu import ppu_pkg::*; ();

    // Three frames for the frame-bound tests plus margin
    localparam int TIMEOUT_CYCLES = 1_400_000;

    // Beam position sampled in the visible window
    localparam int SAMPLE_LINE = 100;
    localparam int SAMPLE_X    = 300;
    // Middle of the horizontal sync pulse
    localparam int HSYNC_X = H_BACK + H_VISIBLE + H_FRONT + H_SYNC / 2;

    logic       clock25;
    logic       reset_n;
    logic       req_i;
    bus_req_t   bus_i;
    logic       ack_o;
    logic [7:0] rdata_o;
    logic       nmi_o;
    rgb_t       rgb_o;
    logic       hs_o;
    logic       vs_o;

    logic [31:0] lfsr_q = 32'he6a2_8432;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycles = 0;
    string       cur_test = "";
    // Expected palette contents as written by the tests
    color_idx_t  pal_model [32];

    `include "tb_tasks.svh"

    ppu_top dut (
        .clock25 (clock25),
        .reset_n (reset_n),
        .req_i   (req_i),
        .bus_i   (bus_i),
        .ack_o   (ack_o),
        .rdata_o (rdata_o),
        .nmi_o   (nmi_o),
        .rgb_o   (rgb_o),
        .hs_o    (hs_o),
        .vs_o    (vs_o)
    );

    // 8 ns clock
    initial begin
        clock25 = 1'b0;
        forever #4 clock25 = ~clock25;
    end

    // Run limit
    always @(posedge clock25) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles in %s", cycles, cur_test);
            $display("Test FAILED");
            $finish;
        end
    end

    // One line per finished test
    task automatic report_test(input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            $display("%s: pass", cur_test);
        end else begin
            $display("%s: fail, %0d bad checks", cur_test, errors - start_errors);
            tests_failed++;
        end
    endtask

    // --------------------------------------
    task automatic palette_round_trip();
        logic [7:0] value;
        logic [7:0] got;
        int         start;
        start    = errors;
        cur_test = "palette round trip";
        set_address(PAL_BASE);
        // Upper two bits written random, stored as zero
        for (int i = 0; i < 32; i++) begin
            random_bits(8, value);
            pal_model[i] = value[5:0];
            bus_write(REG_DATA, value);
        end
        set_address(PAL_BASE);
        for (int i = 0; i < 32; i++) begin
            bus_read(REG_DATA, got);
            check_byte($sformatf("entry %0d", i), {2'b00, pal_model[i]}, got);
        end
        report_test(start);
    endtask

    task automatic wide_step_and_drop();
        logic [7:0] value_a;
        logic [7:0] value_b;
        logic [7:0] got;
        int         start;
        start    = errors;
        cur_test = "wide step and drop";
        bus_write(REG_CTRL, 8'h04);
        set_address(14'h3EE0);
        random_bits(8, value_a);
        random_bits(8, value_b);
        // First write dropped, step of 32 lands on 3F00
        bus_write(REG_DATA, value_a);
        bus_write(REG_DATA, value_b);
        pal_model[0] = value_b[5:0];
        set_address(PAL_BASE);
        bus_read(REG_DATA, got);
        check_byte("read 3F00", {2'b00, value_b[5:0]}, got);
        set_address(14'h3EE0);
        bus_read(REG_DATA, got);
        check_byte("read 3EE0", 8'h00, got);
        bus_write(REG_CTRL, 8'h00);
        report_test(start);
    endtask

    task automatic address_latch_reset();
        logic [7:0] got;
        int         start;
        start    = errors;
        cur_test = "address latch reset";
        // Leaves the toggle pointing at the low byte
        bus_write(REG_ADDR, 8'h12);
        bus_read(REG_STATUS, got);
        bus_write(REG_ADDR, 8'h3F);
        bus_write(REG_ADDR, 8'h05);
        bus_read(REG_DATA, got);
        check_byte("entry 5", {2'b00, pal_model[5]}, got);
        report_test(start);
    endtask

    task automatic backdrop_on_screen();
        logic [7:0] value;
        color_idx_t colour;
        int         start;
        start    = errors;
        cur_test = "backdrop on screen";
        random_bits(6, value);
        colour = value[5:0];
        set_address(PAL_BASE);
        bus_write(REG_DATA, {2'b00, colour});
        pal_model[0] = colour;
        // First high vs_o sample shows beam position 0,0
        while (vs_o !== 1'b0)
            @(negedge clock25);
        while (vs_o !== 1'b1)
            @(negedge clock25);
        repeat (SAMPLE_LINE * H_TOTAL + SAMPLE_X) @(negedge clock25);
        if (hs_o !== 1'b1 || vs_o !== 1'b1) begin
            $display("%s: sync is not high inside the visible window", cur_test);
            errors++;
        end
        check_rgb("visible", MASTER_RGB[colour], rgb_o);
        repeat (HSYNC_X - SAMPLE_X) @(negedge clock25);
        if (hs_o !== 1'b0) begin
            $display("%s: hs_o is not low during the sync pulse", cur_test);
            errors++;
        end
        check_rgb("hsync", rgb_t'(12'h000), rgb_o);
        report_test(start);
    endtask

    task automatic vblank_and_nmi();
        logic [7:0] got;
        int         start;
        start    = errors;
        cur_test = "vblank and nmi";
        bus_write(REG_CTRL, 8'h80);
        while (nmi_o !== 1'b1)
            @(negedge clock25);
        bus_read(REG_STATUS, got);
        check_byte("first status bit 7", 8'h80, got & 8'h80);
        if (nmi_o !== 1'b0) begin
            $display("%s: nmi_o stayed high after the status read", cur_test);
            errors++;
        end
        bus_read(REG_STATUS, got);
        check_byte("second status bit 7", 8'h00, got & 8'h80);
        bus_write(REG_CTRL, 8'h00);
        report_test(start);
    endtask

    // --------------------------------------
    initial begin
        reset_n = 1'b0;
        req_i   = 1'b0;
        bus_i   = '0;
        // Three rising edges in reset, release on a falling edge
        repeat (3) @(posedge clock25);
        @(negedge clock25);
        reset_n = 1'b1;

        palette_round_trip();
        wide_step_and_drop();
        address_latch_reset();
        backdrop_on_screen();
        vblank_and_nmi();

        $display("Tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+tests
logic/ppu_pkg.sv
logic/video_timing.sv
logic/palette_ram.sv
logic/color_out.sv
logic/ppu_regs.sv
logic/ppu_top.sv
tests/tb_ppu.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_ppu
FILELIST  = verilog.f

OBJ_DIR = obj_dir
SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) $(wildcard tests/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | awk '{ print } /^Test OK$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
